// File: Makefile
.PHONY: sim clean

sim:
	verilator --binary --timing --assert -Wno-fatal --top-module io_controller_tb \
		-f sim.f -o io_controller_sim
	-./obj_dir/io_controller_sim > sim.log 2>&1
	cat sim.log
	! grep -q "TEST RESULT: FAIL" sim.log
	grep -q "TEST RESULT: PASS" sim.log

clean:
	rm -rf obj_dir sim.log

// File: sim.f
verilog/io_pkg.sv
verilog/io_bus_fsm.sv
verilog/mem_ctrl_regs.sv
verilog/dma_chan_regs.sv
verilog/irq_ctrl.sv
verilog/io_controller.sv
testbench/io_controller_chk.sv
testbench/io_controller_tb.sv

// File: testbench/io_controller_chk.sv
`timescale 1ns/100ps
`default_nettype none

module io_controller_chk (
   input wire logic clk,
   input wire logic rst,
   input wire logic wen_i,
   input wire logic ren_i,
   input wire logic ack_i,
   input wire logic wr_stb_i,
   input wire logic to_gp0_i,
   input wire logic to_gp1_i
);

   // register write strobe only inside an acknowledged cycle
   assert property (@(posedge clk) disable iff (rst) wr_stb_i |-> ack_i)
      else $error("wr_stb_o high without ack_o");

   assert property (@(posedge clk) disable iff (rst) to_gp0_i |=> !to_gp0_i)
      else $error("to_gp0_o longer than one cycle");

   assert property (@(posedge clk) disable iff (rst) to_gp1_i |=> !to_gp1_i)
      else $error("to_gp1_o longer than one cycle");

   // ack drops only once the cpu has released both request levels
   assert property (@(posedge clk) disable iff (rst) $fell(ack_i) |-> $past(!wen_i && !ren_i))
      else $error("ack_o fell while a request was still high");

endmodule

bind io_bus_fsm io_controller_chk u_chk (
   .clk      (clk),
   .rst      (rst),
   .wen_i    (wen_i),
   .ren_i    (ren_i),
   .ack_i    (ack_o),
   .wr_stb_i (wr_stb_o),
   .to_gp0_i (to_gp0_o),
   .to_gp1_i (to_gp1_o)
);

`default_nettype wire

// File: testbench/io_controller_tb.sv
`timescale 1ns/100ps
`default_nettype none

module io_controller_tb import io_pkg::*; ();

   localparam int N_RANDOM_WR      = 40;
   localparam int BURST_CYCLES     = 24;
   localparam int FULL_STALL       = 7;   // cycles the gpu fifo stays full
   localparam int RDY_STALL        = 5;   // cycles before gpuread is ready
   localparam int PLANNED_ACCESSES = 200;
   localparam int TIMEOUT_CYCLES   = PLANNED_ACCESSES * 40 + FULL_STALL + RDY_STALL;

   logic clk = 1'b0;
   logic rst;
   word_t addr, wdata, rdata;
   logic  wen, ren, ack;
   ben_t  ben;
   logic  to_gp0, to_gp1, gpu_ren, gpu_rdy, gpu_fifo_full;
   word_t gp0, gp1, gpu_stat, gpu_read, dpcr;
   word_t [NUM_DMA_CH-1:0][2:0] dma_ctrl;   // chcr, bcr, madr per channel
   logic [NUM_DMA_CH-1:0] madr_incr, madr_decr, madr_new, bcr_decr;
   word_t [NUM_DMA_CH-1:0] madr_load;
   logic [NUM_IRQ-1:0] irq_src, interrupts;

   // register map model
   word_t mem_m [MEM_CTRL_COUNT];
   word_t ram_m, dpcr_m;
   word_t madr_m [NUM_DMA_CH];
   word_t bcr_m  [NUM_DMA_CH];
   word_t chcr_m [NUM_DMA_CH];
   logic [NUM_IRQ-1:0] stat_m, mask_m;

   word_t rng;
   logic  checks_on, rd_pending;
   word_t rd_exp, rd_addr;
   logic  seen_gp0, seen_gp1, seen_gpu_ren;
   word_t seen_gp0_data, seen_gp1_data;
   int unsigned cycle_count = 0;

   io_controller uut (
      .clk (clk), .rst (rst),
      .addr_i (addr), .data_i (wdata), .wen_i (wen), .ren_i (ren), .ben_i (ben),
      .ack_o (ack), .data_o (rdata),
      .to_gp0_o (to_gp0), .to_gp1_o (to_gp1), .gp0_o (gp0), .gp1_o (gp1),
      .gpu_ren_o (gpu_ren), .gpu_rdy_i (gpu_rdy), .gpu_fifo_full_i (gpu_fifo_full),
      .gpu_stat_i (gpu_stat), .gpu_read_i (gpu_read),
      .dpcr_o (dpcr), .dma_ctrl_o (dma_ctrl),
      .madr_incr_i (madr_incr), .madr_decr_i (madr_decr), .madr_new_i (madr_new),
      .bcr_decr_i (bcr_decr), .madr_load_i (madr_load),
      .irq_src_i (irq_src), .interrupts_o (interrupts)
   );

   always #5 clk = ~clk;

   task automatic stop_with_failure();
      $display("TEST RESULT: FAIL");
      $fatal(1, "stopped at first error");
   endtask

   task automatic mismatch(input string what, input word_t got, input word_t exp);
      $display("MISMATCH time=%0t %s got %h expected %h", $time, what, got, exp);
      stop_with_failure();
   endtask

   task automatic fail_plain(input string what);
      $display("ERROR time=%0t %s", $time, what);
      stop_with_failure();
   endtask

   function automatic word_t xorshift32(input word_t s);
      word_t x;
      x = s;
      x = x ^ (x << 13);
      x = x ^ (x >> 17);
      x = x ^ (x << 5);
      return x;
   endfunction

   function word_t next_rand();
      rng = xorshift32(rng);
      return rng;
   endfunction

   function automatic word_t merge_lanes(input word_t old_w, input word_t new_w, input ben_t b);
      word_t res;
      for (int i = 0; i < 4; i++) begin
         res[8*i +: 8] = b[i] ? new_w[8*i +: 8] : old_w[8*i +: 8];
      end
      return res;
   endfunction

   // bit 0 of the field becomes the msb of the block size
   function automatic logic [5:0] reverse6(input logic [5:0] v);
      return {v[0], v[1], v[2], v[3], v[4], v[5]};
   endfunction

   function automatic word_t random_reg_addr(input word_t r);
      case (r[31:30])
         2'd0:    return MEM_CTRL_BASE + 4 * (r[15:0] % 9);
         2'd1:    return r[0] ? RAM_SIZE_ADDR : DPCR_ADDR;
         default: return DMA_BASE + 16 * (r[15:0] % 7) + 4 * (r[23:16] % 3);
      endcase
   endfunction

   task automatic reset_model();
      mem_m = '{32'h1F00_0000, 32'h1F80_2000, 32'h0013_243F, 32'h0000_3022, 32'h0013_243F,
                32'h2009_31E1, 32'h0002_0843, 32'h0007_0777, 32'h0003_1125};
      ram_m  = 32'h0000_0B88;
      dpcr_m = 32'h0765_4321;
      for (int n = 0; n < NUM_DMA_CH; n++) begin
         madr_m[n] = '0;
         bcr_m[n]  = '0;
         chcr_m[n] = '0;
      end
      stat_m = '0;
      mask_m = '0;
   endtask

   // expected value of a bus read from the current model state
   function automatic word_t expected_read(input word_t a);
      word_t v;
      v = '0;   // unmapped
      for (int i = 0; i < MEM_CTRL_COUNT; i++) begin
         if (a == MEM_CTRL_BASE + 4 * i) v = mem_m[i];
      end
      for (int n = 0; n < NUM_DMA_CH; n++) begin
         if (a == DMA_BASE + 16 * n)     v = madr_m[n];
         if (a == DMA_BASE + 16 * n + 4) v = bcr_m[n];
         if (a == DMA_BASE + 16 * n + 8) v = chcr_m[n];
      end
      if (a == RAM_SIZE_ADDR) v = ram_m;
      if (a == DPCR_ADDR)     v = dpcr_m;
      if (a == I_STAT_ADDR)   v = word_t'(stat_m);
      if (a == I_MASK_ADDR)   v = word_t'(mask_m);
      if (a == GPU_GP0_ADDR)  v = gpu_read;
      if (a == GPU_GP1_ADDR)  v = gpu_stat;
      return v;
   endfunction

   task automatic apply_write(input word_t a, input word_t d, input ben_t b);
      word_t mw;
      mw = merge_lanes(word_t'(mask_m), d, {2'b00, b[1:0]});
      for (int i = 0; i < MEM_CTRL_COUNT; i++) begin
         if (a == MEM_CTRL_BASE + 4 * i) mem_m[i] = merge_lanes(mem_m[i], d, b);
      end
      for (int n = 0; n < NUM_DMA_CH; n++) begin
         if (a == DMA_BASE + 16 * n)     madr_m[n] = merge_lanes(madr_m[n], d, b);
         if (a == DMA_BASE + 16 * n + 4) bcr_m[n]  = merge_lanes(bcr_m[n], d, b);
         if (a == DMA_BASE + 16 * n + 8) chcr_m[n] = merge_lanes(chcr_m[n], d, b);
      end
      if (a == RAM_SIZE_ADDR) ram_m = merge_lanes(ram_m, d, b);
      if (a == DPCR_ADDR)     dpcr_m = merge_lanes(dpcr_m, d, b);
      if (a == I_STAT_ADDR) begin
         for (int i = 0; i < NUM_IRQ; i++) begin
            if (b[i / 8] && !d[i]) stat_m[i] = 1'b0;   // zero bits acknowledge
         end
      end
      if (a == I_MASK_ADDR)   mask_m = mw[NUM_IRQ-1:0];
   endtask

   task automatic apply_dma_step(input logic [NUM_DMA_CH-1:0] ld, inc, dec, bdec,
                                 input word_t [NUM_DMA_CH-1:0] ldv);
      for (int n = 0; n < NUM_DMA_CH; n++) begin
         if (ld[n]) begin
            madr_m[n] = ldv[n];
         end else if (dec[n]) begin   // decrement beats increment
            madr_m[n] = madr_m[n] - 32'd4;
         end else if (inc[n]) begin
            madr_m[n] = madr_m[n] + 32'd4;
         end
         if (bdec[n]) begin
            bcr_m[n][31:16] = bcr_m[n][31:16] - {10'b0, reverse6(bcr_m[n][5:0])};
         end
      end
   endtask

   task automatic write_word(input word_t a, input word_t d, input ben_t b);
      @(posedge clk);
      addr  <= a;
      wdata <= d;
      ben   <= b;
      wen   <= 1'b1;
      @(posedge clk);
      while (!ack) @(posedge clk);
      seen_gp0      = to_gp0;   // values of the first ack cycle
      seen_gp1      = to_gp1;
      seen_gp0_data = gp0;
      seen_gp1_data = gp1;
      wen <= 1'b0;
      apply_write(a, d, b);   // registers update on this edge
      while (ack) @(posedge clk);
   endtask

   task automatic read_word(input word_t a);
      @(posedge clk);
      addr <= a;
      ben  <= 4'hF;
      ren  <= 1'b1;
      @(posedge clk);
      while (!ack) @(posedge clk);
      seen_gpu_ren = gpu_ren;
      rd_addr    = a;
      rd_exp     = expected_read(a);
      rd_pending = 1'b1;   // data_o valid from here until ack drops
      @(posedge clk);
      ren <= 1'b0;   // request held one cycle past ack, ack stays high
      @(posedge clk);
      rd_pending = 1'b0;
      while (ack) @(posedge clk);
   endtask

   task automatic irq_pulse(input logic [NUM_IRQ-1:0] bits);
      @(posedge clk);
      irq_src <= bits;
      @(posedge clk);
      irq_src <= '0;
      stat_m = stat_m | bits;
   endtask

   task automatic dma_burst(input int cycles);
      logic [NUM_DMA_CH-1:0]  ld, inc, dec, bdec;
      word_t [NUM_DMA_CH-1:0] ldv;
      word_t r1, r2;
      ld   = '0;
      inc  = '0;
      dec  = '0;
      bdec = '0;
      ldv  = '0;
      for (int c = 0; c <= cycles; c++) begin
         @(posedge clk);
         if (c > 0) apply_dma_step(ld, inc, dec, bdec, ldv);   // driven one edge ago
         if (c < cycles) begin
            r1   = next_rand();
            r2   = next_rand();
            ld   = r1[6:0] & r1[13:7] & r1[20:14];   // loads are rare
            inc  = r2[6:0];
            dec  = r2[13:7] & r2[20:14];
            bdec = r1[27:21];
            for (int n = 0; n < NUM_DMA_CH; n++) ldv[n] = next_rand();
         end else begin
            ld   = '0;
            inc  = '0;
            dec  = '0;
            bdec = '0;
         end
         madr_new  <= ld;
         madr_incr <= inc;
         madr_decr <= dec;
         bcr_decr  <= bdec;
         madr_load <= ldv;
      end
   endtask

   task automatic read_all_dma();
      for (int n = 0; n < NUM_DMA_CH; n++) begin
         for (int k = 0; k < 3; k++) read_word(DMA_BASE + 16 * n + 4 * k);
      end
   endtask

   // compares at the falling edge where every output is settled
   always @(negedge clk) begin
      if (checks_on) begin
         if (rd_pending) begin
            assert (rdata == rd_exp)
               else mismatch($sformatf("data_o read of %h", rd_addr), rdata, rd_exp);
         end
         assert (interrupts == (stat_m & mask_m))
            else mismatch("interrupts_o", word_t'(interrupts), word_t'(stat_m & mask_m));
         assert (dpcr == dpcr_m) else mismatch("dpcr_o", dpcr, dpcr_m);
         for (int n = 0; n < NUM_DMA_CH; n++) begin
            assert (dma_ctrl[n][0] == madr_m[n])
               else mismatch($sformatf("madr ch %0d", n), dma_ctrl[n][0], madr_m[n]);
            assert (dma_ctrl[n][1] == bcr_m[n])
               else mismatch($sformatf("bcr ch %0d", n), dma_ctrl[n][1], bcr_m[n]);
            assert (dma_ctrl[n][2] == chcr_m[n])
               else mismatch($sformatf("chcr ch %0d", n), dma_ctrl[n][2], chcr_m[n]);
         end
      end
   end

   always @(posedge clk) begin
      cycle_count <= cycle_count + 1;
      if (cycle_count >= TIMEOUT_CYCLES) begin
         $display("timeout after %0d cycles, an access never completed", cycle_count);
         stop_with_failure();
      end
   end

   initial begin : stimulus
      word_t a, d, r;
      rst           = 1'b1;
      addr          = '0;
      wdata         = '0;
      wen           = 1'b0;
      ren           = 1'b0;
      ben           = '0;
      gpu_rdy       = 1'b1;
      gpu_fifo_full = 1'b0;
      gpu_stat      = '0;
      gpu_read      = '0;
      madr_incr     = '0;
      madr_decr     = '0;
      madr_new      = '0;
      bcr_decr      = '0;
      madr_load     = '0;
      irq_src = '0;
      rng = 32'h8c6c_e09c;
      checks_on = 1'b0;
      rd_pending = 1'b0;
      reset_model();
      repeat (5) @(posedge clk);
      rst <= 1'b0;
      @(posedge clk);
      checks_on = 1'b1;

      // reset values and unmapped holes
      for (int i = 0; i < MEM_CTRL_COUNT; i++) read_word(MEM_CTRL_BASE + 4 * i);
      read_word(RAM_SIZE_ADDR);
      read_word(DPCR_ADDR);
      read_word(I_STAT_ADDR);
      read_word(I_MASK_ADDR);
      read_all_dma();
      read_word(32'h1F80_1064);
      read_word(32'h1F80_108C);   // fourth word of channel 0

      for (int i = 0; i < N_RANDOM_WR; i++) begin
         a = random_reg_addr(next_rand());
         d = next_rand();
         r = next_rand();
         write_word(a, d, r[3:0]);
         read_word(a);
      end

      // dma hardware updates
      for (int n = 0; n < NUM_DMA_CH; n++) begin
         write_word(DMA_BASE + 16 * n, next_rand(), 4'hF);
         write_word(DMA_BASE + 16 * n + 4, next_rand(), 4'hF);
      end
      dma_burst(BURST_CYCLES);
      read_all_dma();
      dma_burst(BURST_CYCLES);
      read_all_dma();

      // interrupt status and mask
      write_word(I_MASK_ADDR, next_rand(), 4'b0011);
      read_word(I_MASK_ADDR);
      for (int i = 0; i < 4; i++) begin
         r = next_rand();
         irq_pulse(r[NUM_IRQ-1:0]);
      end
      read_word(I_STAT_ADDR);
      r = next_rand();
      write_word(I_STAT_ADDR, next_rand(), r[3:0]);
      read_word(I_STAT_ADDR);
      irq_pulse(11'h7FF);
      write_word(I_STAT_ADDR, 32'h0, 4'b0011);   // acknowledge everything
      read_word(I_STAT_ADDR);

      d = next_rand();
      write_word(GPU_GP1_ADDR, d, 4'hF);
      assert (seen_gp1 && !seen_gp0) else fail_plain("GP1 write did not pulse to_gp1_o");
      assert (seen_gp1_data == d) else mismatch("gp1_o", seen_gp1_data, d);

      d = next_rand();
      @(posedge clk);
      gpu_fifo_full <= 1'b1;
      fork
         write_word(GPU_GP0_ADDR, d, 4'hF);
         begin
            repeat (FULL_STALL) begin
               @(posedge clk);
               assert (!ack && !to_gp0)
                  else fail_plain("GP0 write went through while the GPU FIFO was full");
            end
            gpu_fifo_full <= 1'b0;
         end
      join
      assert (seen_gp0) else fail_plain("GP0 write did not pulse to_gp0_o with ack_o");
      assert (seen_gp0_data == d) else mismatch("gp0_o", seen_gp0_data, d);

      @(posedge clk);
      gpu_rdy  <= 1'b0;
      gpu_read <= next_rand();
      gpu_stat <= next_rand();
      fork
         read_word(GPU_GP0_ADDR);
         begin
            repeat (RDY_STALL) begin
               @(posedge clk);
               assert (!ack && !gpu_ren)
                  else fail_plain("GP0 read finished before the GPU had data ready");
            end
            gpu_rdy  <= 1'b1;
            gpu_read <= next_rand();   // new word arrives together with ready
         end
      join
      assert (seen_gpu_ren) else fail_plain("GP0 read did not pulse gpu_ren_o");
      read_word(GPU_GP1_ADDR);
      assert (!seen_gpu_ren) else fail_plain("GP1 read popped the GPU read port");

      repeat (4) @(posedge clk);
      $display("TEST RESULT: PASS");
      $finish;
   end

endmodule

`default_nettype wire

// File: verilog/dma_chan_regs.sv
`timescale 1ns/100ps
`default_nettype none

module dma_chan_regs import io_pkg::*; (
   input  wire logic                   clk,
   input  wire logic                   rst,
   input  wire word_t                  addr_i,
   input  wire word_t                  data_i,
   input  wire ben_t                   ben_i,
   input  wire logic                   wr_stb_i,
   input  wire logic [NUM_DMA_CH-1:0]  madr_new_i,
   input  wire logic [NUM_DMA_CH-1:0]  madr_incr_i,
   input  wire logic [NUM_DMA_CH-1:0]  madr_decr_i,
   input  wire logic [NUM_DMA_CH-1:0]  bcr_decr_i,
   input  wire word_t [NUM_DMA_CH-1:0] madr_load_i,
   output word_t [NUM_DMA_CH-1:0][2:0] dma_ctrl_o,
   output word_t                       dpcr_o,
   output word_t                       rd_data_o,
   output logic                        hit_o
);

   word_t madr_q [0:NUM_DMA_CH-1];
   word_t bcr_q  [0:NUM_DMA_CH-1];
   word_t chcr_q [0:NUM_DMA_CH-1];
   word_t dpcr_q;

   word_t      ch_off;
   logic [2:0] ch_sel;
   logic [1:0] reg_sel;   // 0 madr, 1 bcr, 2 chcr
   logic       ch_hit, dpcr_hit;

   // block size field sits bit-reversed in the low bits
   function automatic logic [5:0] rev6(logic [5:0] v);
      logic [5:0] r;
      for (int i = 0; i < 6; i++) begin
         r[i] = v[5-i];
      end
      return r;
   endfunction

   assign ch_off   = addr_i - DMA_BASE;
   assign ch_sel   = ch_off[6:4];
   assign reg_sel  = ch_off[3:2];
   assign ch_hit   = (ch_off < NUM_DMA_CH * 16) && (ch_off[1:0] == 2'b00) &&
                     (reg_sel != 2'd3);
   assign dpcr_hit = (addr_i == DPCR_ADDR);

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         for (int n = 0; n < NUM_DMA_CH; n++) begin
            madr_q[n] <= '0;
            bcr_q[n]  <= '0;
            chcr_q[n] <= '0;
         end
         dpcr_q <= DPCR_RESET;
      end else begin
         for (int n = 0; n < NUM_DMA_CH; n++) begin
            // bus write to a word overrides the hardware update of that word
            if (wr_stb_i && ch_hit && ch_sel == n && reg_sel == 2'd0) begin
               madr_q[n] <= byte_merge(madr_q[n], data_i, ben_i);
            end else if (madr_new_i[n]) begin
               madr_q[n] <= madr_load_i[n];
            end else if (madr_decr_i[n]) begin   // decrement wins over increment
               madr_q[n] <= madr_q[n] - MADR_STEP;
            end else if (madr_incr_i[n]) begin
               madr_q[n] <= madr_q[n] + MADR_STEP;
            end

            if (wr_stb_i && ch_hit && ch_sel == n && reg_sel == 2'd1) begin
               bcr_q[n] <= byte_merge(bcr_q[n], data_i, ben_i);
            end else if (bcr_decr_i[n]) begin
               bcr_q[n][31:16] <= bcr_q[n][31:16] - {10'b0, rev6(bcr_q[n][5:0])};
            end

            if (wr_stb_i && ch_hit && ch_sel == n && reg_sel == 2'd2) begin
               chcr_q[n] <= byte_merge(chcr_q[n], data_i, ben_i);
            end
         end
         if (wr_stb_i && dpcr_hit) begin
            dpcr_q <= byte_merge(dpcr_q, data_i, ben_i);
         end
      end
   end

   always_comb begin
      for (int n = 0; n < NUM_DMA_CH; n++) begin
         dma_ctrl_o[n] = {chcr_q[n], bcr_q[n], madr_q[n]};
      end
   end

   assign dpcr_o = dpcr_q;
   assign hit_o  = ch_hit | dpcr_hit;

   always_comb begin
      if (ch_hit) begin
         case (reg_sel)
            2'd0:    rd_data_o = madr_q[ch_sel];
            2'd1:    rd_data_o = bcr_q[ch_sel];
            default: rd_data_o = chcr_q[ch_sel];
         endcase
      end else if (dpcr_hit) begin
         rd_data_o = dpcr_q;
      end else begin
         rd_data_o = '0;
      end
   end

endmodule

`default_nettype wire

// File: verilog/io_bus_fsm.sv
`timescale 1ns/100ps
`default_nettype none

module io_bus_fsm import io_pkg::*; (
   input  wire logic  clk,
   input  wire logic  rst,
   input  wire word_t addr_i,
   input  wire word_t data_i,
   input  wire logic  wen_i,
   input  wire logic  ren_i,
   input  wire logic  gpu_rdy_i,
   input  wire logic  gpu_fifo_full_i,
   input  wire word_t gpu_read_i,
   input  wire word_t gpu_stat_i,
   input  wire word_t mem_rd_i,
   input  wire word_t dma_rd_i,
   input  wire word_t irq_rd_i,
   input  wire logic  mem_hit_i,
   input  wire logic  dma_hit_i,
   input  wire logic  irq_hit_i,
   output logic       ack_o,
   output logic       wr_stb_o,
   output word_t      data_o,
   output logic       to_gp0_o,
   output logic       to_gp1_o,
   output word_t      gp0_o,
   output word_t      gp1_o,
   output logic       gpu_ren_o
);

   bus_state_e state_q, state_d;

   logic  is_gp0, is_gp1;
   word_t rd_sel;

   assign is_gp0 = (addr_i == GPU_GP0_ADDR);
   assign is_gp1 = (addr_i == GPU_GP1_ADDR);

   // gpu words first, then whichever register block claims the address
   always_comb begin
      if (is_gp0) begin
         rd_sel = gpu_read_i;
      end else if (is_gp1) begin
         rd_sel = gpu_stat_i;
      end else if (mem_hit_i) begin
         rd_sel = mem_rd_i;
      end else if (dma_hit_i) begin
         rd_sel = dma_rd_i;
      end else if (irq_hit_i) begin
         rd_sel = irq_rd_i;
      end else begin
         rd_sel = '0;   // unmapped
      end
   end

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         state_q <= IDLE;
      end else begin
         state_q <= state_d;
      end
   end

   always_comb begin
      state_d   = state_q;
      ack_o     = 1'b0;
      wr_stb_o  = 1'b0;
      to_gp0_o  = 1'b0;
      to_gp1_o  = 1'b0;
      gp0_o     = '0;
      gp1_o     = '0;
      gpu_ren_o = 1'b0;

      case (state_q)
         IDLE: begin
            if (ren_i) begin
               state_d = READ;
            end else if (wen_i) begin
               state_d = WRITE;
            end
         end
         READ: begin
            state_d = LATCH;   // read data registered on this edge
         end
         LATCH: begin
            if (!is_gp0) begin
               ack_o   = 1'b1;
               state_d = WAIT;
            end else if (gpu_rdy_i) begin
               gpu_ren_o = 1'b1;   // pop gpuread
               ack_o     = 1'b1;
               state_d   = WAIT;
            end
         end
         WRITE: begin
            if (is_gp0) begin
               if (!gpu_fifo_full_i) begin   // hold while command fifo is full
                  to_gp0_o = 1'b1;
                  gp0_o    = data_i;
                  ack_o    = 1'b1;
                  state_d  = WAIT;
               end
            end else if (is_gp1) begin
               to_gp1_o = 1'b1;
               gp1_o    = data_i;
               ack_o    = 1'b1;
               state_d  = WAIT;
            end else begin
               wr_stb_o = 1'b1;   // register blocks decode the address
               ack_o    = 1'b1;
               state_d  = WAIT;
            end
         end
         WAIT: begin
            ack_o = 1'b1;
            if (!wen_i && !ren_i) begin
               state_d = IDLE;
            end
         end
         default: begin
            state_d = IDLE;
         end
      endcase
   end

   // loaded at the end of READ, gp0 data replaces it on the pop edge
   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         data_o <= '0;
      end else if (state_q == READ) begin
         data_o <= rd_sel;
      end else if (gpu_ren_o) begin
         data_o <= gpu_read_i;
      end
   end

endmodule

`default_nettype wire

// File: verilog/io_controller.sv
`timescale 1ns/100ps
`default_nettype none

module io_controller import io_pkg::*; (
   input  wire logic                   clk,
   input  wire logic                   rst,

   // cpu side
   input  wire word_t                  addr_i,
   input  wire word_t                  data_i,
   input  wire logic                   wen_i,
   input  wire logic                   ren_i,
   input  wire ben_t                   ben_i,
   output logic                        ack_o,
   output word_t                       data_o,

   // gpu ports
   output logic                        to_gp0_o,
   output logic                        to_gp1_o,
   output word_t                       gp0_o,
   output word_t                       gp1_o,
   output logic                        gpu_ren_o,
   input  wire logic                   gpu_rdy_i,
   input  wire logic                   gpu_fifo_full_i,
   input  wire word_t                  gpu_stat_i,
   input  wire word_t                  gpu_read_i,

   // dma channels
   output word_t                       dpcr_o,
   output word_t [NUM_DMA_CH-1:0][2:0] dma_ctrl_o,
   input  wire logic [NUM_DMA_CH-1:0]  madr_incr_i,
   input  wire logic [NUM_DMA_CH-1:0]  madr_decr_i,
   input  wire logic [NUM_DMA_CH-1:0]  madr_new_i,
   input  wire logic [NUM_DMA_CH-1:0]  bcr_decr_i,
   input  wire word_t [NUM_DMA_CH-1:0] madr_load_i,

   // interrupts
   input  wire logic [NUM_IRQ-1:0]     irq_src_i,
   output logic [NUM_IRQ-1:0]          interrupts_o
);

   logic  wr_stb;
   word_t mem_rd, dma_rd, irq_rd;
   logic  mem_hit, dma_hit, irq_hit;

   io_bus_fsm u_fsm (
      .clk             (clk),
      .rst             (rst),
      .addr_i          (addr_i),
      .data_i          (data_i),
      .wen_i           (wen_i),
      .ren_i           (ren_i),
      .gpu_rdy_i       (gpu_rdy_i),
      .gpu_fifo_full_i (gpu_fifo_full_i),
      .gpu_read_i      (gpu_read_i),
      .gpu_stat_i      (gpu_stat_i),
      .mem_rd_i        (mem_rd),
      .dma_rd_i        (dma_rd),
      .irq_rd_i        (irq_rd),
      .mem_hit_i       (mem_hit),
      .dma_hit_i       (dma_hit),
      .irq_hit_i       (irq_hit),
      .ack_o           (ack_o),
      .wr_stb_o        (wr_stb),
      .data_o          (data_o),
      .to_gp0_o        (to_gp0_o),
      .to_gp1_o        (to_gp1_o),
      .gp0_o           (gp0_o),
      .gp1_o           (gp1_o),
      .gpu_ren_o       (gpu_ren_o)
   );

   mem_ctrl_regs u_mem (
      .clk       (clk),
      .rst       (rst),
      .addr_i    (addr_i),
      .data_i    (data_i),
      .ben_i     (ben_i),
      .wr_stb_i  (wr_stb),
      .rd_data_o (mem_rd),
      .hit_o     (mem_hit)
   );

   dma_chan_regs u_dma (
      .clk         (clk),
      .rst         (rst),
      .addr_i      (addr_i),
      .data_i      (data_i),
      .ben_i       (ben_i),
      .wr_stb_i    (wr_stb),
      .madr_new_i  (madr_new_i),
      .madr_incr_i (madr_incr_i),
      .madr_decr_i (madr_decr_i),
      .bcr_decr_i  (bcr_decr_i),
      .madr_load_i (madr_load_i),
      .dma_ctrl_o  (dma_ctrl_o),
      .dpcr_o      (dpcr_o),
      .rd_data_o   (dma_rd),
      .hit_o       (dma_hit)
   );

   irq_ctrl u_irq (
      .clk          (clk),
      .rst          (rst),
      .addr_i       (addr_i),
      .data_i       (data_i),
      .ben_i        (ben_i),
      .wr_stb_i     (wr_stb),
      .irq_src_i    (irq_src_i),
      .interrupts_o (interrupts_o),
      .rd_data_o    (irq_rd),
      .hit_o        (irq_hit)
   );

endmodule

`default_nettype wire

// File: verilog/io_pkg.sv
`default_nettype none

package io_pkg;

   typedef logic [31:0] word_t;   // one bus word
   typedef logic [3:0]  ben_t;    // one enable per byte lane

   localparam int NUM_DMA_CH = 7;
   localparam int NUM_IRQ    = 11;

   // memory control window, nine words at a stride of 4
   localparam word_t MEM_CTRL_BASE  = 32'h1F80_1000;
   localparam int    MEM_CTRL_COUNT = 9;
   localparam word_t RAM_SIZE_ADDR  = 32'h1F80_1060;

   localparam word_t I_STAT_ADDR = 32'h1F80_1070;
   localparam word_t I_MASK_ADDR = 32'h1F80_1074;

   localparam word_t DMA_BASE  = 32'h1F80_1080;   // channel n at +16*n
   localparam word_t DPCR_ADDR = 32'h1F80_10F0;

   localparam word_t GPU_GP0_ADDR = 32'h1F80_1810;   // write gp0, read gpuread
   localparam word_t GPU_GP1_ADDR = 32'h1F80_1814;   // write gp1, read gpustat

   localparam word_t MEM_CTRL_RESET [0:MEM_CTRL_COUNT-1] = '{
      32'h1F00_0000,   // exp1 base
      32'h1F80_2000,   // exp2 base
      32'h0013_243F,   // exp1 timing
      32'h0000_3022,   // exp3 timing
      32'h0013_243F,   // bios rom timing
      32'h2009_31E1,   // spu timing
      32'h0002_0843,   // cdrom timing
      32'h0007_0777,   // exp2 timing
      32'h0003_1125    // shared delay
   };

   localparam word_t RAM_SIZE_RESET = 32'h0000_0B88;
   localparam word_t DPCR_RESET     = 32'h0765_4321;   // channel priorities

   localparam word_t MADR_STEP = 32'd4;   // one word per transfer

   typedef enum logic [4:0] {
      IDLE  = 5'b00001,
      READ  = 5'b00010,
      LATCH = 5'b00100,
      WRITE = 5'b01000,
      WAIT  = 5'b10000
   } bus_state_e;

   // new bytes replace old ones on the enabled lanes only
   function automatic word_t byte_merge(word_t old_w, word_t new_w, ben_t ben);
      word_t res;
      res = old_w;
      for (int b = 0; b < 4; b++) begin
         if (ben[b]) begin
            res[8*b +: 8] = new_w[8*b +: 8];
         end
      end
      return res;
   endfunction

endpackage

`default_nettype wire

// File: verilog/irq_ctrl.sv
`timescale 1ns/100ps
`default_nettype none

module irq_ctrl import io_pkg::*; (
   input  wire logic                clk,
   input  wire logic                rst,
   input  wire word_t               addr_i,
   input  wire word_t               data_i,
   input  wire ben_t                ben_i,
   input  wire logic                wr_stb_i,
   input  wire logic [NUM_IRQ-1:0]  irq_src_i,
   output logic [NUM_IRQ-1:0]       interrupts_o,
   output word_t                    rd_data_o,
   output logic                     hit_o
);

   logic [NUM_IRQ-1:0] stat_q, mask_q;
   logic [NUM_IRQ-1:0] stat_clr;
   logic [15:0]        lane_en;
   word_t              mask_merged;
   logic               stat_hit, mask_hit;

   assign stat_hit = (addr_i == I_STAT_ADDR);
   assign mask_hit = (addr_i == I_MASK_ADDR);

   // writing 0 acknowledges, only on the enabled low lanes
   assign lane_en     = {{8{ben_i[1]}}, {8{ben_i[0]}}};
   assign stat_clr    = NUM_IRQ'(lane_en & ~data_i[15:0]);
   assign mask_merged = byte_merge(word_t'(mask_q), data_i, {2'b00, ben_i[1:0]});

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         stat_q <= '0;
         mask_q <= '0;
      end else begin
         if (wr_stb_i && stat_hit) begin
            stat_q <= (stat_q & ~stat_clr) | irq_src_i;   // new source survives the ack
         end else begin
            stat_q <= stat_q | irq_src_i;
         end
         if (wr_stb_i && mask_hit) begin
            mask_q <= mask_merged[NUM_IRQ-1:0];
         end
      end
   end

   assign interrupts_o = stat_q & mask_q;
   assign hit_o        = stat_hit | mask_hit;
   assign rd_data_o    = stat_hit ? word_t'(stat_q) :
                         mask_hit ? word_t'(mask_q) : '0;

endmodule

`default_nettype wire

// File: verilog/mem_ctrl_regs.sv
`timescale 1ns/100ps
`default_nettype none

module mem_ctrl_regs import io_pkg::*; (
   input  wire logic  clk,
   input  wire logic  rst,
   input  wire word_t addr_i,
   input  wire word_t data_i,
   input  wire ben_t  ben_i,
   input  wire logic  wr_stb_i,
   output word_t      rd_data_o,
   output logic       hit_o
);

   localparam int IDX_W = $clog2(MEM_CTRL_COUNT);

   word_t mem_q [0:MEM_CTRL_COUNT-1];   // delay/size words
   word_t ram_size_q;

   word_t             mc_off;
   logic [IDX_W-1:0]  mc_idx;
   logic              mc_hit, ram_hit;

   assign mc_off  = addr_i - MEM_CTRL_BASE;   // wraps high below the base
   assign mc_hit  = (mc_off < MEM_CTRL_COUNT * 4) && (mc_off[1:0] == 2'b00);
   assign mc_idx  = mc_off[2 +: IDX_W];
   assign ram_hit = (addr_i == RAM_SIZE_ADDR);

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         for (int i = 0; i < MEM_CTRL_COUNT; i++) begin
            mem_q[i] <= MEM_CTRL_RESET[i];
         end
         ram_size_q <= RAM_SIZE_RESET;
      end else begin
         if (wr_stb_i && mc_hit) begin
            mem_q[mc_idx] <= byte_merge(mem_q[mc_idx], data_i, ben_i);
         end
         if (wr_stb_i && ram_hit) begin
            ram_size_q <= byte_merge(ram_size_q, data_i, ben_i);
         end
      end
   end

   assign hit_o     = mc_hit | ram_hit;
   assign rd_data_o = mc_hit  ? mem_q[mc_idx] :
                      ram_hit ? ram_size_q    : '0;

endmodule

`default_nettype wire
